// ==== Makefile ====
# Verilator build and run of the ooo_core testbench
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module ooo_core_tb \
		-f ooo_core.f -o ooo_core_sim

run: compile
	./obj_dir/ooo_core_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "SOME TESTS FAILED" $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== ooo_core.f ====
source/ooo_pkg.sv
source/alu_unit.sv
source/pipelined_multiplier.sv
source/cdb_arbiter.sv
source/reservation_station.sv
source/reorder_buffer.sv
source/dispatch_unit.sv
source/ooo_core.sv
testbench/ooo_core_sva.sv
testbench/ooo_core_checker.sv
testbench/ooo_core_tb.sv

// ==== source/alu_unit.sv ====
`default_nettype none

module alu_unit (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 issue,
	input  ooo_pkg::data_t       a,
	input  ooo_pkg::data_t       b,
	input  ooo_pkg::alu_payload_t payload,
	input  ooo_pkg::rob_tag_t    tag,
	input  logic                 written,
	output logic                 busy,
	output ooo_pkg::cdb_t        result
);
	import ooo_pkg::*;

	data_t value;

	always_comb begin
		case (payload.op)
			ALU_LI:  value = payload.imm;
			ALU_ADD: value = a + b;
			ALU_SUB: value = a - b;
			ALU_AND: value = a & b;
			ALU_XOR: value = a ^ b;
			default: value = '0;
		endcase
	end

	// held result blocks the station until the arbiter takes it
	assign busy = result.valid & ~written;

	always_ff @(posedge clock) begin
		if (reset) begin
			result.valid <= 1'b0;
		end else if (issue) begin
			result <= '{valid: 1'b1, tag: tag, value: value};
		end else if (written) begin
			result.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== source/cdb_arbiter.sv ====
`default_nettype none

module cdb_arbiter (
	input  ooo_pkg::cdb_t alu_result,
	input  ooo_pkg::cdb_t mult_result,
	output ooo_pkg::cdb_t cdb,
	output logic          alu_written,
	output logic          mult_written
);

	// fixed priority, multiplier first
	// it has the deeper pipe to drain
	always_comb begin
		mult_written = mult_result.valid;
		alu_written  = alu_result.valid & ~mult_result.valid;
		if (mult_written) begin
			cdb = mult_result;
		end else if (alu_written) begin
			cdb = alu_result;
		end else begin
			// idle bus
			cdb = '0;
		end
	end

endmodule

`default_nettype wire

// ==== source/dispatch_unit.sv ====
`default_nettype none

module dispatch_unit (
	input  logic               clock,
	input  logic               reset,
	input  logic               dispatch_valid,
	input  ooo_pkg::dispatch_t dispatch_inst,
	input  logic               rob_full,
	input  logic               alu_rs_full,
	input  logic               mult_rs_full,
	input  ooo_pkg::rob_tag_t  alloc_tag,
	input  ooo_pkg::data_t     rob_value_rs1,
	input  ooo_pkg::data_t     rob_value_rs2,
	input  logic               rob_ready_rs1,
	input  logic               rob_ready_rs2,
	input  ooo_pkg::cdb_t      cdb,
	input  ooo_pkg::commit_t   commit,
	output ooo_pkg::rob_tag_t  lookup_tag_rs1,
	output ooo_pkg::rob_tag_t  lookup_tag_rs2,
	output logic               rob_alloc,
	output logic               alu_alloc,
	output logic               mult_alloc,
	output ooo_pkg::operand_t  src1,
	output ooo_pkg::operand_t  src2,
	output logic               dispatch_stall
);
	import ooo_pkg::*;

	data_t                regfile [REG_COUNT];
	logic [REG_COUNT-1:0] map_valid;
	rob_tag_t             map_tag [REG_COUNT];
	// commits come in order, so a counter tracks the retiring tag
	rob_tag_t             retire_tag;
	logic                 rob_full_q, alu_full_q, mult_full_q;
	logic                 accept, uses_src;
	reg_idx_t             rs1, rs2, rd;

	// order of lookup: arch file, rob entry, live broadcast
	function automatic operand_t rename_src(
		input logic     use_src,
		input logic     mapped,
		input rob_tag_t tag,
		input data_t    arch_value,
		input data_t    rob_value,
		input logic     rob_ready,
		input cdb_t     bus
	);
		operand_t op;
		op.ready = 1'b1;
		op.tag   = tag;
		op.value = use_src ? arch_value : '0;
		if (use_src && mapped) begin
			if (rob_ready) begin
				op.value = rob_value;
			end else if (bus.valid && bus.tag == tag) begin
				op.value = bus.value;
			end else begin
				op.ready = 1'b0;
			end
		end
		return op;
	endfunction

	assign rs1 = dispatch_inst.rs1;
	assign rs2 = dispatch_inst.rs2;
	assign rd  = dispatch_inst.rd;

	// full flags are already next-cycle fullness, so registering them is exact
	assign dispatch_stall = rob_full_q
		| ((dispatch_inst.op_class == CLASS_MULT) ? mult_full_q : alu_full_q);
	assign accept     = dispatch_valid & ~dispatch_stall;
	assign rob_alloc  = accept;
	assign alu_alloc  = accept & (dispatch_inst.op_class == CLASS_ALU);
	assign mult_alloc = accept & (dispatch_inst.op_class == CLASS_MULT);

	// li reads no registers
	assign uses_src = !(dispatch_inst.op_class == CLASS_ALU && dispatch_inst.alu_op == ALU_LI);

	assign lookup_tag_rs1 = map_tag[rs1];
	assign lookup_tag_rs2 = map_tag[rs2];
	assign src1 = rename_src(uses_src, map_valid[rs1], map_tag[rs1], regfile[rs1],
		rob_value_rs1, rob_ready_rs1, cdb);
	assign src2 = rename_src(uses_src, map_valid[rs2], map_tag[rs2], regfile[rs2],
		rob_value_rs2, rob_ready_rs2, cdb);

	always_ff @(posedge clock) begin
		if (reset) begin
			map_valid   <= '0;
			retire_tag  <= '0;
			rob_full_q  <= 1'b0;
			alu_full_q  <= 1'b0;
			mult_full_q <= 1'b0;
			for (int i = 0; i < REG_COUNT; i++) begin
				regfile[i] <= '0;
			end
		end else begin
			rob_full_q  <= rob_full;
			alu_full_q  <= alu_rs_full;
			mult_full_q <= mult_rs_full;
			if (commit.valid) begin
				regfile[commit.rd] <= commit.data;
				retire_tag         <= retire_tag + 1'b1;
				// a newer writer keeps its mapping
				if (map_tag[commit.rd] == retire_tag) begin
					map_valid[commit.rd] <= 1'b0;
				end
			end
			// rename rd, wins over a same-cycle clear
			if (accept) begin
				map_valid[rd] <= 1'b1;
				map_tag[rd]   <= alloc_tag;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/ooo_core.sv ====
`default_nettype none

module ooo_core #(
	parameter int ALU_RS_DEPTH  = 4,
	parameter int MULT_RS_DEPTH = 2,
	parameter int MULT_STAGES   = 3
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               dispatch_valid,
	input  ooo_pkg::dispatch_t dispatch_inst,
	output logic               dispatch_stall,
	output ooo_pkg::commit_t   commit
);
	import ooo_pkg::*;

	// allocation side
	logic          rob_alloc, alu_alloc, mult_alloc;
	logic          rob_full, alu_rs_full, mult_rs_full;
	rob_tag_t      alloc_tag, lookup_tag_rs1, lookup_tag_rs2;
	data_t         rob_value_rs1, rob_value_rs2;
	logic          rob_ready_rs1, rob_ready_rs2;
	operand_t      src1, src2;
	alu_payload_t  alu_payload;
	mult_payload_t mult_payload;

	// issue and writeback side
	logic          alu_issue, mult_issue;
	data_t         alu_a, alu_b, mult_a, mult_b;
	alu_payload_t  alu_issue_payload;
	mult_payload_t mult_issue_payload;
	rob_tag_t      alu_issue_tag, mult_issue_tag;
	logic          alu_busy, mult_busy;
	cdb_t          alu_result, mult_result, cdb;
	logic          alu_written, mult_written;

	// station payloads straight from the decoded fields
	assign alu_payload.op  = dispatch_inst.alu_op;
	assign alu_payload.imm = dispatch_inst.imm;
	assign mult_payload.op = dispatch_inst.mult_op;

	////////////////////////////////////////////////////////////////////////////
	// rename, allocate, retire
	////////////////////////////////////////////////////////////////////////////

	dispatch_unit dispatch_0 (
		.clock, .reset, .dispatch_valid, .dispatch_inst,
		.rob_full, .alu_rs_full, .mult_rs_full, .alloc_tag,
		.rob_value_rs1, .rob_value_rs2, .rob_ready_rs1, .rob_ready_rs2,
		.cdb, .commit, .lookup_tag_rs1, .lookup_tag_rs2,
		.rob_alloc, .alu_alloc, .mult_alloc, .src1, .src2, .dispatch_stall
	);

	reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) rob_0 (
		.clock, .reset, .rob_alloc, .alloc_rd(dispatch_inst.rd), .cdb,
		.lookup_tag_rs1, .lookup_tag_rs2, .alloc_tag, .full(rob_full),
		.rob_value_rs1, .rob_value_rs2, .rob_ready_rs1, .rob_ready_rs2, .commit
	);

	////////////////////////////////////////////////////////////////////////////
	// stations, units, broadcast
	////////////////////////////////////////////////////////////////////////////

	reservation_station #(.RS_DEPTH(ALU_RS_DEPTH), .payload_t(alu_payload_t)) alu_rs (
		.clock, .reset, .alloc(alu_alloc), .src1, .src2, .alloc_payload(alu_payload),
		.alloc_tag, .cdb, .unit_busy(alu_busy), .full(alu_rs_full),
		.issue(alu_issue), .issue_a(alu_a), .issue_b(alu_b),
		.issue_payload(alu_issue_payload), .issue_tag(alu_issue_tag)
	);

	reservation_station #(.RS_DEPTH(MULT_RS_DEPTH), .payload_t(mult_payload_t)) mult_rs (
		.clock, .reset, .alloc(mult_alloc), .src1, .src2, .alloc_payload(mult_payload),
		.alloc_tag, .cdb, .unit_busy(mult_busy), .full(mult_rs_full),
		.issue(mult_issue), .issue_a(mult_a), .issue_b(mult_b),
		.issue_payload(mult_issue_payload), .issue_tag(mult_issue_tag)
	);

	alu_unit alu_0 (
		.clock, .reset, .issue(alu_issue), .a(alu_a), .b(alu_b),
		.payload(alu_issue_payload), .tag(alu_issue_tag), .written(alu_written),
		.busy(alu_busy), .result(alu_result)
	);

	pipelined_multiplier #(.MULT_STAGES(MULT_STAGES)) mult_0 (
		.clock, .reset, .issue(mult_issue), .a(mult_a), .b(mult_b),
		.payload(mult_issue_payload), .tag(mult_issue_tag), .written(mult_written),
		.busy(mult_busy), .result(mult_result)
	);

	cdb_arbiter arbiter_0 (
		.alu_result, .mult_result, .cdb, .alu_written, .mult_written
	);

endmodule

`default_nettype wire

// ==== source/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths and sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int DATA_WIDTH = 16;
	localparam int REG_COUNT  = 8;
	// tag type below is sized from this depth
	localparam int ROB_DEPTH  = 8;

	typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;
	typedef logic [DATA_WIDTH-1:0]        data_t;
	typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;

	// operation encodings
	typedef enum logic [2:0] {ALU_LI, ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR} alu_op_t;
	typedef enum logic {MULT_MUL, MULT_MULHU} mult_op_t;
	typedef enum logic {CLASS_ALU, CLASS_MULT} op_class_t;

	////////////////////////////////////////////////////////////////////////////
	// bundles
	////////////////////////////////////////////////////////////////////////////

	// decoded instruction at the dispatch port
	typedef struct packed {
		op_class_t op_class;
		alu_op_t   alu_op;
		mult_op_t  mult_op;
		reg_idx_t  rd;
		reg_idx_t  rs1;
		reg_idx_t  rs2;
		data_t     imm;
	} dispatch_t;

	// renamed source: value when ready, else the producer tag
	typedef struct packed {
		logic     ready;
		rob_tag_t tag;
		data_t    value;
	} operand_t;

	typedef struct packed {
		alu_op_t op;
		data_t   imm;
	} alu_payload_t;

	typedef struct packed {
		mult_op_t op;
	} mult_payload_t;

	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		data_t    value;
	} cdb_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		data_t    data;
	} commit_t;

endpackage

`default_nettype wire

// ==== source/pipelined_multiplier.sv ====
`default_nettype none

module pipelined_multiplier #(
	parameter int MULT_STAGES = 3
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  issue,
	input  ooo_pkg::data_t        a,
	input  ooo_pkg::data_t        b,
	input  ooo_pkg::mult_payload_t payload,
	input  ooo_pkg::rob_tag_t     tag,
	input  logic                  written,
	output logic                  busy,
	output ooo_pkg::cdb_t         result
);
	import ooo_pkg::*;

	logic [2*DATA_WIDTH-1:0] product;
	data_t                   selected;
	cdb_t                    stage [MULT_STAGES];
	logic                    advance;

	// full product, half picked up front
	assign product  = a * b;
	assign selected = (payload.op == MULT_MULHU) ? product[2*DATA_WIDTH-1:DATA_WIDTH]
		: product[DATA_WIDTH-1:0];

	// whole pipe freezes behind an ungranted result
	assign advance = ~stage[MULT_STAGES-1].valid | written;
	assign busy    = ~advance;
	assign result  = stage[MULT_STAGES-1];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < MULT_STAGES; i++) begin
				stage[i].valid <= 1'b0;
			end
		end else if (advance) begin
			stage[0] <= '{valid: issue, tag: tag, value: selected};
			for (int i = 1; i < MULT_STAGES; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/reorder_buffer.sv ====
`default_nettype none

module reorder_buffer #(
	parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              rob_alloc,
	input  ooo_pkg::reg_idx_t alloc_rd,
	input  ooo_pkg::cdb_t     cdb,
	input  ooo_pkg::rob_tag_t lookup_tag_rs1,
	input  ooo_pkg::rob_tag_t lookup_tag_rs2,
	output ooo_pkg::rob_tag_t alloc_tag,
	output logic              full,
	output ooo_pkg::data_t    rob_value_rs1,
	output ooo_pkg::data_t    rob_value_rs2,
	output logic              rob_ready_rs1,
	output logic              rob_ready_rs2,
	output ooo_pkg::commit_t  commit
);
	import ooo_pkg::*;

	localparam int CW = $clog2(ROB_DEPTH + 1);

	// entry payload
	reg_idx_t entry_rd    [ROB_DEPTH];
	data_t    entry_value [ROB_DEPTH];

	// entry and pointer control
	logic [ROB_DEPTH-1:0] entry_ready;
	rob_tag_t             head, tail;
	logic [CW-1:0]        count, count_next;
	logic                 retire;

	assign alloc_tag = tail;

	// head retires once its result is in
	assign retire     = (count != '0) && entry_ready[head];
	assign count_next = count + CW'(rob_alloc) - CW'(retire);
	// fullness after this cycle
	assign full       = (count_next == CW'(ROB_DEPTH));

	// operand reads for dispatch
	assign rob_value_rs1 = entry_value[lookup_tag_rs1];
	assign rob_value_rs2 = entry_value[lookup_tag_rs2];
	assign rob_ready_rs1 = entry_ready[lookup_tag_rs1];
	assign rob_ready_rs2 = entry_ready[lookup_tag_rs2];

	////////////////////////////////////////////////////////////////////////////
	// payload capture
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (cdb.valid) begin
			entry_value[cdb.tag] <= cdb.value;
		end
		if (rob_alloc) begin
			entry_rd[tail] <= alloc_rd;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// pointers, ready flags, commit register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head        <= '0;
			tail        <= '0;
			count       <= '0;
			entry_ready <= '0;
			commit      <= '0;
		end else begin
			count        <= count_next;
			commit.valid <= retire;
			if (retire) begin
				commit.rd   <= entry_rd[head];
				commit.data <= entry_value[head];
				head        <= head + 1'b1;
			end
			// broadcast lands here, commit follows a cycle later
			if (cdb.valid) begin
				entry_ready[cdb.tag] <= 1'b1;
			end
			// tail slot is always free, so no clash with the broadcast
			if (rob_alloc) begin
				entry_ready[tail] <= 1'b0;
				tail              <= tail + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/reservation_station.sv ====
`default_nettype none

module reservation_station #(
	parameter int  RS_DEPTH  = 4,
	parameter type payload_t = ooo_pkg::alu_payload_t
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              alloc,
	input  ooo_pkg::operand_t src1,
	input  ooo_pkg::operand_t src2,
	input  payload_t          alloc_payload,
	input  ooo_pkg::rob_tag_t alloc_tag,
	input  ooo_pkg::cdb_t     cdb,
	input  logic              unit_busy,
	output logic              full,
	output logic              issue,
	output ooo_pkg::data_t    issue_a,
	output ooo_pkg::data_t    issue_b,
	output payload_t          issue_payload,
	output ooo_pkg::rob_tag_t issue_tag
);
	import ooo_pkg::*;

	localparam int IW = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

	typedef struct packed {
		operand_t a;
		operand_t b;
		payload_t payload;
		rob_tag_t tag;
	} entry_t;

	entry_t              entries [RS_DEPTH];
	logic [RS_DEPTH-1:0] used;
	logic [IW-1:0]       issue_idx, free_idx;
	logic                found;
	int                  occupied;

	// downward scan, so the lowest index wins for both picks
	always_comb begin
		found     = 1'b0;
		issue_idx = '0;
		free_idx  = '0;
		occupied  = 0;
		for (int i = RS_DEPTH - 1; i >= 0; i--) begin
			if (used[i] && entries[i].a.ready && entries[i].b.ready) begin
				found     = 1'b1;
				issue_idx = IW'(i);
			end
			if (!used[i]) begin
				free_idx = IW'(i);
			end
			occupied += int'(used[i]);
		end
	end

	assign issue         = found & ~unit_busy;
	assign issue_a       = entries[issue_idx].a.value;
	assign issue_b       = entries[issue_idx].b.value;
	assign issue_payload = entries[issue_idx].payload;
	assign issue_tag     = entries[issue_idx].tag;
	// occupancy after this cycle
	assign full = (occupied + int'(alloc) - int'(issue)) == RS_DEPTH;

	// operand wakeup from the broadcast, then new entry
	always_ff @(posedge clock) begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (used[i] && cdb.valid) begin
				if (!entries[i].a.ready && entries[i].a.tag == cdb.tag) begin
					entries[i].a.ready <= 1'b1;
					entries[i].a.value <= cdb.value;
				end
				if (!entries[i].b.ready && entries[i].b.tag == cdb.tag) begin
					entries[i].b.ready <= 1'b1;
					entries[i].b.value <= cdb.value;
				end
			end
		end
		if (alloc) begin
			entries[free_idx] <= '{a: src1, b: src2, payload: alloc_payload, tag: alloc_tag};
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			used <= '0;
		end else begin
			if (issue) begin
				used[issue_idx] <= 1'b0;
			end
			if (alloc) begin
				used[free_idx] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/ooo_core_checker.sv ====
`default_nettype none

module ooo_core_checker #(
	parameter int BURST_TEST = 5
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             dispatch_valid,
	input  logic             dispatch_stall,
	input  ooo_pkg::commit_t commit,
	input  ooo_pkg::commit_t expected,
	input  logic [7:0]       expected_test,
	input  logic             expected_last,
	input  logic [7:0]       active_test,
	output int               checked,
	output int               errors,
	output int               tests_passed,
	output int               tests_failed
);
	timeunit 1ns;
	timeprecision 100ps;
	import ooo_pkg::*;

	// one accepted instruction still waiting for its commit
	typedef struct packed {
		logic [7:0] test;
		logic       last;
		commit_t    value;
	} pending_t;

	pending_t outstanding [$];
	pending_t entry, head;
	int       commit_count, error_count, pass_count, fail_count;
	int       test_errors, idle_errors;
	logic     started       = 1'b0;
	logic     burst_stalled = 1'b0;

	task automatic close_test(input int test, input int failures);
		if (failures == 0) begin
			pass_count++;
			$display("test %0d passed", test);
		end else begin
			fail_count++;
			$display("test %0d failed with %0d errors", test, failures);
		end
	endtask

	always @(posedge clock) begin
		if (!reset) begin
			////////////////////////////////////////////////////////////////////////////
			// quiet core between reset and the first dispatch
			////////////////////////////////////////////////////////////////////////////
			if (!started) begin
				if (commit.valid) begin
					$display("commit pulse seen before any instruction was dispatched");
					idle_errors++;
				end
				if (dispatch_stall) begin
					$display("dispatch_stall high before any instruction was dispatched");
					idle_errors++;
				end
				if (dispatch_valid) begin
					started = 1'b1;
					close_test(1, idle_errors);
					error_count += idle_errors;
				end
			end

			// accepted instructions in program order
			if (expected.valid) begin
				entry.test  = expected_test;
				entry.last  = expected_last;
				entry.value = expected;
				outstanding.push_back(entry);
			end
			// the multiply burst has to back up dispatch
			if (dispatch_stall && active_test == 8'(BURST_TEST)) begin
				burst_stalled = 1'b1;
			end

			////////////////////////////////////////////////////////////////////////////
			// commit compare
			////////////////////////////////////////////////////////////////////////////
			if (commit.valid) begin
				if (outstanding.size() == 0) begin
					$display("unexpected commit to r%0d with no instruction outstanding",
						commit.rd);
					error_count++;
				end else begin
					head = outstanding.pop_front();
					commit_count++;
					if (commit.rd !== head.value.rd) begin
						$display("Mismatch commit.rd: expected 0x%h, got 0x%h in test %0d",
							head.value.rd, commit.rd, head.test);
						test_errors++;
					end
					if (commit.data !== head.value.data) begin
						$display("Mismatch commit.data: expected 0x%h, got 0x%h in test %0d",
							head.value.data, commit.data, head.test);
						test_errors++;
					end
					// last row of a test closes it
					if (head.last) begin
						if (head.test == 8'(BURST_TEST) && !burst_stalled) begin
							$display("dispatch_stall never rose during the burst of test %0d",
								head.test);
							test_errors++;
						end
						close_test(head.test, test_errors);
						error_count += test_errors;
						test_errors = 0;
					end
				end
			end
		end
		checked      <= commit_count;
		errors       <= error_count;
		tests_passed <= pass_count;
		tests_failed <= fail_count;
	end

endmodule

`default_nettype wire

// ==== testbench/ooo_core_sva.sv ====
`default_nettype none

module ooo_core_sva (
	input logic             clock,
	input logic             reset,
	input ooo_pkg::commit_t commit
);
	timeunit 1ns;
	timeprecision 100ps;

	// no retirement in reset or in the first cycle out of it
	no_commit_near_reset: assert property (@(posedge clock)
		($past(reset) || $past(reset, 2)) |-> !commit.valid)
		else $error("commit pulse during reset or in the cycle after it");

	// every field of a retiring result is driven
	commit_known: assert property (@(posedge clock) disable iff (reset)
		commit.valid |-> !$isunknown(commit))
		else $error("commit carries unknown bits while valid");

endmodule

bind ooo_core ooo_core_sva ooo_core_sva_i (.clock, .reset, .commit);

`default_nettype wire

// ==== testbench/ooo_core_tb.sv ====
`default_nettype none

module ooo_core_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import ooo_pkg::*;

	// stimulus row with the commit it must produce
	typedef struct packed {
		logic [7:0] test;
		logic       burst;
		dispatch_t  inst;
		commit_t    expected;
	} row_t;

	// idle check plus five table tests
	localparam int TEST_COUNT = 6;

	logic       clock;
	logic       reset;
	logic       dispatch_valid;
	dispatch_t  dispatch_inst;
	logic       dispatch_stall;
	commit_t    commit;

	// toward the checker
	commit_t    expected;
	logic [7:0] expected_test;
	logic       expected_last;
	logic [7:0] active_test;
	int         checked, errors, tests_passed, tests_failed;

	row_t       rows [$];
	int         cycle_count = 0;
	int         cycle_limit = 0;

	ooo_core ooo_core_i (
		.clock, .reset, .dispatch_valid, .dispatch_inst, .dispatch_stall, .commit
	);

	ooo_core_checker scoreboard (
		.clock, .reset, .dispatch_valid, .dispatch_stall, .commit,
		.expected, .expected_test, .expected_last, .active_test,
		.checked, .errors, .tests_passed, .tests_failed
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////////////////////

	task automatic alu_row(input int test, input alu_op_t op, input int rd, input int rs1,
		input int rs2, input int imm, input int result);
		row_t row;
		row               = '0;
		row.test          = 8'(test);
		row.inst.op_class = CLASS_ALU;
		row.inst.alu_op   = op;
		row.inst.rd       = reg_idx_t'(rd);
		row.inst.rs1      = reg_idx_t'(rs1);
		row.inst.rs2      = reg_idx_t'(rs2);
		row.inst.imm      = data_t'(imm);
		// commit goes to the instruction's own rd
		row.expected      = '{valid: 1'b1, rd: reg_idx_t'(rd), data: data_t'(result)};
		rows.push_back(row);
	endtask

	task automatic mult_row(input int test, input logic burst, input mult_op_t op,
		input int rd, input int rs1, input int rs2, input int result);
		row_t row;
		row               = '0;
		row.test          = 8'(test);
		row.burst         = burst;
		row.inst.op_class = CLASS_MULT;
		row.inst.mult_op  = op;
		row.inst.rd       = reg_idx_t'(rd);
		row.inst.rs1      = reg_idx_t'(rs1);
		row.inst.rs2      = reg_idx_t'(rs2);
		row.expected      = '{valid: 1'b1, rd: reg_idx_t'(rd), data: data_t'(result)};
		rows.push_back(row);
	endtask

	task automatic build_table();
		// basic alu ops on two loaded values
		alu_row(2, ALU_LI,  1, 0, 0, 'h1234, 'h1234);
		alu_row(2, ALU_LI,  2, 0, 0, 'h0f0f, 'h0f0f);
		alu_row(2, ALU_ADD, 3, 1, 2, 0, 'h2143);
		alu_row(2, ALU_SUB, 4, 1, 2, 0, 'h0325);
		alu_row(2, ALU_AND, 5, 1, 2, 0, 'h0204);
		alu_row(2, ALU_XOR, 6, 1, 2, 0, 'h1d3b);
		// each op reads the one before
		alu_row(3, ALU_LI,  1, 0, 0, 'h0003, 'h0003);
		alu_row(3, ALU_ADD, 1, 1, 1, 0, 'h0006);
		alu_row(3, ALU_ADD, 2, 1, 1, 0, 'h000c);
		alu_row(3, ALU_SUB, 3, 2, 1, 0, 'h0006);
		alu_row(3, ALU_XOR, 4, 3, 2, 0, 'h000a);
		alu_row(3, ALU_AND, 5, 4, 2, 0, 'h0008);
		alu_row(3, ALU_SUB, 6, 5, 4, 0, 'hfffe);
		// product halves, alu work behind the multiplies
		alu_row(4, ALU_LI,  1, 0, 0, 'h1234, 'h1234);
		alu_row(4, ALU_LI,  2, 0, 0, 'h0100, 'h0100);
		mult_row(4, 1'b0, MULT_MUL,   3, 1, 2, 'h3400);
		mult_row(4, 1'b0, MULT_MULHU, 4, 1, 2, 'h0012);
		alu_row(4, ALU_LI,  7, 0, 0, 'hffff, 'hffff);
		mult_row(4, 1'b0, MULT_MULHU, 0, 7, 7, 'hfffe);
		mult_row(4, 1'b0, MULT_MUL,   6, 7, 7, 'h0001);
		alu_row(4, ALU_ADD, 5, 2, 2, 0, 'h0200);
		alu_row(4, ALU_XOR, 3, 1, 2, 0, 'h1334);
		// back to back dependent multiplies, powers of three
		alu_row(5, ALU_LI,  1, 0, 0, 'h0003, 'h0003);
		mult_row(5, 1'b1, MULT_MUL,   2, 1, 1, 'h0009);
		mult_row(5, 1'b1, MULT_MUL,   2, 2, 1, 'h001b);
		mult_row(5, 1'b1, MULT_MUL,   2, 2, 1, 'h0051);
		mult_row(5, 1'b1, MULT_MUL,   2, 2, 1, 'h00f3);
		mult_row(5, 1'b1, MULT_MUL,   2, 2, 1, 'h02d9);
		mult_row(5, 1'b1, MULT_MUL,   2, 2, 1, 'h088b);
		mult_row(5, 1'b1, MULT_MUL,   2, 2, 1, 'h19a1);
		mult_row(5, 1'b1, MULT_MULHU, 3, 2, 2, 'h0290);
		mult_row(5, 1'b1, MULT_MUL,   4, 2, 2, 'hd741);
		// later writer of r5 wins, even when it finishes first
		alu_row(6, ALU_LI,  5, 0, 0, 'h1111, 'h1111);
		alu_row(6, ALU_LI,  5, 0, 0, 'h2222, 'h2222);
		alu_row(6, ALU_ADD, 6, 5, 5, 0, 'h4444);
		mult_row(6, 1'b0, MULT_MUL,   5, 1, 1, 'h0009);
		alu_row(6, ALU_LI,  5, 0, 0, 'habcd, 'habcd);
		alu_row(6, ALU_ADD, 7, 5, 1, 0, 'habd0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// dispatch
	////////////////////////////////////////////////////////////////////////////

	// expected strobe lasts one cycle unless set again
	task automatic next_cycle();
		@(posedge clock);
		expected.valid <= 1'b0;
	endtask

	task automatic dispatch_row(input int i);
		int idle;
		idle = rows[i].burst ? 0 : int'($urandom % 3);
		repeat (idle) begin
			dispatch_valid <= 1'b0;
			next_cycle();
		end
		dispatch_valid <= 1'b1;
		dispatch_inst  <= rows[i].inst;
		active_test    <= rows[i].test;
		// held until a cycle without stall
		do begin
			next_cycle();
		end while (dispatch_stall);
		expected      <= rows[i].expected;
		expected_test <= rows[i].test;
		expected_last <= (i == rows.size() - 1) || (rows[i + 1].test != rows[i].test);
	endtask

	initial begin
		void'($urandom(51787));
		reset          = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_inst  = '0;
		expected       = '0;
		expected_test  = '0;
		expected_last  = 1'b0;
		active_test    = '0;
		build_table();
		cycle_limit = 40 + 20 * rows.size();
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		// a few empty cycles for the idle check
		repeat (4) next_cycle();
		for (int i = 0; i < rows.size(); i++) begin
			dispatch_row(i);
		end
		dispatch_valid <= 1'b0;
		next_cycle();
		while (checked < rows.size()) begin
			next_cycle();
		end
		// room for stray or repeated commits to show
		repeat (8) next_cycle();
		$display("%0d tests passed, %0d tests failed, %0d of %0d commits checked, %0d errors",
			tests_passed, tests_failed, checked, rows.size(), errors);
		if (errors == 0 && tests_passed == TEST_COUNT && checked == rows.size()) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// watchdog
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles: %0d of %0d commits never arrived, from test %0d on",
				cycle_count, rows.size() - checked, rows.size(), rows[checked].test);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire
